/* neuron_node.f */
+incdir+tb
design/neuron_pkg.sv
design/mac_if.sv
design/fp_mult.sv
design/fp_add.sv
design/tap_counter.sv
design/node_fsm.sv
design/mac_datapath.sv
design/neuron_node.sv
tb/tb_neuron_node.sv

/* Bender.yml */
package:
  name: neuron_node

sources:
  - design/neuron_pkg.sv
  - design/mac_if.sv
  - design/fp_mult.sv
  - design/fp_add.sv
  - design/tap_counter.sv
  - design/node_fsm.sv
  - design/mac_datapath.sv
  - design/neuron_node.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_neuron_node.sv

/* tb/fp_ref_model.svh */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Single-precision product with flush-to-zero and truncation toward zero.
function automatic fp32_t multiply_ftz(fp32_t a, fp32_t b);
	logic            sign;
	int              exp_r;
	longint unsigned mant;
	sign = a[31] ^ b[31];
	if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
		return 32'h0;
	mant  = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
	exp_r = int'(a[30:23]) + int'(b[30:23]) - 127 - 23;
	while (mant >= 64'h1000000)
	begin
		mant  = mant >> 1; // Dropped bits are the truncation.
		exp_r = exp_r + 1;
	end
	if (exp_r <= 0)
		return 32'h0;
	if (exp_r >= 255)
		return {sign, 8'hFF, 23'h0};
	return {sign, exp_r[7:0], mant[22:0]};
endfunction

// Single-precision sum under the same rules; an exact zero is +0.0.
function automatic fp32_t add_aligned(fp32_t a, fp32_t b);
	fp32_t       x;
	fp32_t       y;
	fp32_t       t;
	int          shift;
	int          exp_r;
	int unsigned mx;
	int unsigned my;
	int unsigned m;
	x = (a[30:23] == 8'd0) ? 32'h0 : a;
	y = (b[30:23] == 8'd0) ? 32'h0 : b;
	if (y[30:0] > x[30:0])
	begin
		t = x;
		x = y;
		y = t;
	end
	if (x[30:23] == 8'd0)
		return 32'h0;
	mx    = {1'b1, x[22:0]};
	my    = (y[30:23] == 8'd0) ? 0 : {1'b1, y[22:0]};
	shift = int'(x[30:23]) - int'(y[30:23]);
	my    = (shift > 24) ? 0 : my >> shift;
	m     = (x[31] == y[31]) ? mx + my : mx - my;
	if (m == 0)
		return 32'h0;
	exp_r = int'(x[30:23]);
	while (m >= 32'h1000000)
	begin
		m     = m >> 1;
		exp_r = exp_r + 1;
	end
	while (m < 32'h800000)
	begin
		m     = m << 1;
		exp_r = exp_r - 1;
	end
	if (exp_r <= 0)
		return 32'h0;
	if (exp_r >= 255)
		return {x[31], 8'hFF, 23'h0};
	return {x[31], exp_r[7:0], m[22:0]};
endfunction

function automatic fp32_t relu(fp32_t x);
	return x[31] ? 32'h0 : x;
endfunction

`endif

/* tb/tb_neuron_node.sv */
`timescale 1ns/10ps

module tb_neuron_node;
	import neuron_pkg::*;

	`include "fp_ref_model.svh"

	logic  clk;
	logic  rst_n;
	logic  start;
	logic  sample_valid;
	fp32_t sample;
	fp32_t result;
	logic  done;
	logic  busy;
	fp32_t taps [NUM_TAPS];

	neuron_node DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.sample_valid (sample_valid),
		.sample       (sample),
		.result       (result),
		.done         (done),
		.busy         (busy)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic compare_result(input string name, input fp32_t got, input fp32_t exp);
		if (got !== exp)
			stop_with_error($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Normal value with an exponent field from 100 to 154 and a random sign.
	function automatic fp32_t random_normal();
		logic [7:0] exp_f;
		exp_f = 8'(100 + $urandom_range(54));
		return {1'($urandom_range(1)), exp_f, 23'($urandom)};
	endfunction

	function automatic fp32_t model_output();
		fp32_t acc;
		acc = 32'h0;
		for (int i = 0; i < NUM_TAPS; i++)
			acc = add_aligned(acc, multiply_ftz(taps[i], WEIGHTS[i]));
		return relu(acc);
	endfunction

	// Taps 16, 22 and 28 have a negated weight right after them, so each pair nets zero.
	task automatic fill_cancelling();
		fp32_t x;
		foreach (taps[i])
			taps[i] = 32'h0;
		for (int k = 16; k < NUM_TAPS; k += 6)
		begin
			x           = random_normal();
			taps[k]     = x;
			taps[k + 1] = x;
		end
	endtask

	task automatic run_node(input bit strays, input fp32_t expected);
		int cycles;
		if (strays)
		begin
			repeat ($urandom_range(2, 1))
			begin
				sample_valid = 1'b1; // Idle strobes must be dropped.
				sample       = random_normal();
				@(negedge clk);
			end
		end
		sample_valid = 1'b0;
		start        = 1'b1;
		@(negedge clk);
		start = 1'b0;
		for (int i = 0; i < NUM_TAPS; i++)
		begin
			repeat ($urandom_range(3))
			begin
				sample_valid = 1'b0;
				sample       = $urandom;
				start        = strays && $urandom_range(1);
				@(negedge clk);
			end
			compare_flag("busy", busy, 1'b1);
			compare_flag("done", done, 1'b0);
			sample_valid = 1'b1;
			sample       = taps[i];
			start        = strays && $urandom_range(1);
			@(negedge clk);
		end
		cycles = 1;
		while (done !== 1'b1)
		begin
			if (cycles >= 12)
				stop_with_error("done never arrived after the last sample of the run");
			compare_flag("busy", busy, 1'b1);
			sample_valid = strays;
			start        = strays; // Still busy, so this start is ignored.
			sample       = $urandom;
			@(negedge clk);
			cycles++;
		end
		sample_valid = 1'b0;
		start        = 1'b0;
		if (cycles != 3)
			stop_with_error($sformatf("mismatch done_latency: got 0x%0h, expected 0x3", cycles));
		compare_flag("busy", busy, 1'b0);
		compare_result("result", result, expected);
		@(negedge clk);
		compare_flag("done", done, 1'b0);
		compare_result("result", result, expected); // Held after the pulse.
	endtask

	initial
	begin
		void'($urandom(8));
		rst_n        = 1'b0;
		start        = 1'b0;
		sample_valid = 1'b0;
		sample       = 32'h0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		repeat (3)
		begin
			compare_flag("done", done, 1'b0);
			compare_flag("busy", busy, 1'b0);
			compare_result("result", result, 32'h0);
			sample_valid = 1'b1;
			sample       = random_normal();
			@(negedge clk);
		end
		sample_valid = 1'b0;
		for (int r = 0; r < 200; r++)
		begin
			foreach (taps[i])
				taps[i] = random_normal();
			run_node(1'($urandom_range(1)), model_output());
		end
		for (int r = 0; r < 5; r++)
		begin
			fill_cancelling();
			run_node(1'b1, 32'h0);
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* design/neuron_node.sv */
`timescale 1ns/10ps

module neuron_node (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic              sample_valid,
	input  neuron_pkg::fp32_t sample,
	output neuron_pkg::fp32_t result,
	output logic              done,
	output logic              busy
);

	mac_if u_ctl (.clk(clk));

	node_fsm u_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.sample_valid (sample_valid),
		.busy         (busy),
		.done         (done),
		.ctl          (u_ctl.seq)
	);

	tap_counter u_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.cnt   (u_ctl.cnt)
	);

	mac_datapath u_dp (
		.clk    (clk),
		.rst_n  (rst_n),
		.sample (sample),
		.result (result),
		.ctl    (u_ctl.dp)
	);

endmodule

/* design/mac_datapath.sv */
`timescale 1ns/10ps

module mac_datapath (
	input  logic              clk,
	input  logic              rst_n,
	input  neuron_pkg::fp32_t sample,
	output neuron_pkg::fp32_t result,
	mac_if.dp                 ctl
);
	import neuron_pkg::*;

	fp32_t weight;
	fp32_t prod;
	fp32_t prod_q;
	fp32_t sum;
	fp32_t acc;
	logic  prod_vld;

	assign weight = WEIGHTS[ctl.tap_idx];

	fp_mult u_mult (
		.a (sample),
		.b (weight),
		.p (prod)
	);

	fp_add u_add (
		.a (acc),
		.b (prod_q),
		.s (sum)
	);

	always_ff @(posedge clk)
	begin
		if (ctl.accept)
			prod_q <= prod;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			prod_vld <= 1'b0;
		else
			prod_vld <= ctl.accept && !ctl.clear;
	end

	// The sum starts from +0.0 at every run.
	always_ff @(posedge clk)
	begin
		if (ctl.clear)
			acc <= '0;
		else if (prod_vld)
			acc <= sum;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			result <= '0;
		else if (ctl.finish)
			result <= acc[31] ? '0 : acc; // ReLU.
	end

endmodule

/* design/node_fsm.sv */
`timescale 1ns/10ps

module node_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic sample_valid,
	output logic busy,
	output logic done,
	mac_if.seq   ctl
);
	import neuron_pkg::*;

	node_state_e state;
	node_state_e state_nxt;

	// A start while a run is still finishing is dropped.
	assign ctl.clear  = (state == S_IDLE) && start && !busy;
	assign ctl.accept = (state == S_ACCUM) && sample_valid;

	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:  if (ctl.clear) state_nxt = S_ACCUM;
			S_ACCUM: if (ctl.accept && ctl.last_tap) state_nxt = S_DRAIN;
			S_DRAIN: state_nxt = S_IDLE; // Lets the last product reach the accumulator.
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= S_IDLE;
			ctl.finish <= 1'b0;
			done       <= 1'b0;
			busy       <= 1'b0;
		end
		else
		begin
			state      <= state_nxt;
			ctl.finish <= (state == S_DRAIN);
			done       <= ctl.finish;
			if (ctl.clear)
				busy <= 1'b1;
			else if (ctl.finish)
				busy <= 1'b0; // Falls as done rises.
		end
	end

endmodule

/* design/tap_counter.sv */
`timescale 1ns/10ps

module tap_counter (
	input logic clk,
	input logic rst_n,
	mac_if.cnt  cnt
);
	import neuron_pkg::*;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt.tap_idx <= '0;
		else if (cnt.clear)
			cnt.tap_idx <= '0;
		else if (cnt.accept)
		begin
			// Wrap after the last tap so the weight index stays in range.
			if (cnt.last_tap)
				cnt.tap_idx <= '0;
			else
				cnt.tap_idx <= cnt.tap_idx + 1'b1;
		end
	end

	assign cnt.last_tap = (cnt.tap_idx == tap_idx_t'(NUM_TAPS - 1));

endmodule

/* design/fp_add.sv */
`timescale 1ns/10ps

module fp_add (
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t s
);
	import neuron_pkg::*;

	fp32_t              fa;
	fp32_t              fb;
	fp32_t              big;
	fp32_t              lesser;
	logic [7:0]         exp_diff;
	logic [23:0]        man_big;
	logic [23:0]        man_small;
	logic [23:0]        man_shift;
	logic [24:0]        sum;
	logic [4:0]         lz;
	logic [23:0]        norm;
	logic signed [9:0]  exp_res;
	logic [22:0]        frac;

	// Subnormal operands count as +0.0.
	assign fa = (a[30:23] == 8'd0) ? '0 : a;
	assign fb = (b[30:23] == 8'd0) ? '0 : b;

	always_comb
	begin
		if (fa[30:0] >= fb[30:0])
		begin
			big    = fa;
			lesser = fb;
		end
		else
		begin
			big    = fb;
			lesser = fa;
		end
	end

	assign exp_diff  = big[30:23] - lesser[30:23];
	assign man_big   = (big[30:23] == 8'd0) ? 24'd0 : {1'b1, big[22:0]};
	assign man_small = (lesser[30:23] == 8'd0) ? 24'd0 : {1'b1, lesser[22:0]};
	assign man_shift = man_small >> exp_diff; // Bits shifted out are lost.

	// The larger magnitude is first, so the difference never goes negative.
	assign sum = (big[31] == lesser[31]) ? man_big + man_shift : man_big - man_shift;

	always_comb
	begin
		lz = 5'd0;
		for (int i = 0; i < 24; i++)
		begin
			if (sum[i])
				lz = 5'(23 - i); // The highest set bit wins.
		end
	end

	assign norm = sum[23:0] << lz;

	always_comb
	begin
		if (sum[24])
		begin
			exp_res = $signed({2'b00, big[30:23]}) + 10'sd1;
			frac    = sum[23:1];
		end
		else
		begin
			exp_res = $signed({2'b00, big[30:23]}) - $signed({5'd0, lz});
			frac    = norm[22:0];
		end

		if (sum == 25'd0 || exp_res <= 10'sd0)
			s = '0;
		else if (exp_res >= 10'sd255)
			s = {big[31], 8'hFF, 23'd0};
		else
			s = {big[31], exp_res[7:0], frac};
	end

endmodule

/* design/fp_mult.sv */
`timescale 1ns/10ps

module fp_mult (
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t p
);

	logic               sign;
	logic [47:0]        mant_prod;
	logic signed [9:0]  exp_sum;
	logic [22:0]        frac;

	assign sign = a[31] ^ b[31];

	// Both mantissas carry their hidden one.
	assign mant_prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};

	always_comb
	begin
		exp_sum = $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - 10'sd127;

		// The product of two values in [1,2) lies in [1,4), so one bit of
		// normalization is enough.
		if (mant_prod[47])
		begin
			exp_sum = exp_sum + 10'sd1;
			frac    = mant_prod[46:24];
		end
		else
		begin
			frac = mant_prod[45:23];
		end

		if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
			p = '0; // Zero and subnormal inputs flush to +0.0.
		else if (exp_sum <= 10'sd0)
			p = '0;
		else if (exp_sum >= 10'sd255)
			p = {sign, 8'hFF, 23'd0};
		else
			p = {sign, exp_sum[7:0], frac};
	end

endmodule

/* design/mac_if.sv */
`timescale 1ns/10ps

interface mac_if (input logic clk);
	import neuron_pkg::*;

	logic     clear;    // Restart of a run.
	logic     accept;   // A sample is taken this cycle.
	tap_idx_t tap_idx;
	logic     last_tap;
	logic     finish;   // Loads the result register.

	modport seq (
		output clear, accept, finish,
		input  last_tap
	);

	modport cnt (
		input  clear, accept,
		output tap_idx, last_tap
	);

	modport dp (
		input clear, accept, tap_idx, finish
	);

endinterface

/* design/neuron_pkg.sv */
package neuron_pkg;

	// Number of inputs to the neuron.
	localparam int NUM_TAPS = 30;

	// Raw IEEE-754 single-precision bit pattern.
	typedef logic [31:0] fp32_t;

	typedef logic [4:0] tap_idx_t;

	typedef enum logic [1:0]
	{
		S_IDLE  = 2'd0,
		S_ACCUM = 2'd1,
		S_DRAIN = 2'd2
	} node_state_e;

	// Fixed weights of this node, indexed by tap number.
	localparam fp32_t WEIGHTS [NUM_TAPS] = '{
		32'h3E4CCCCD, 32'hBE99999A, 32'h3F000000,
		32'hBD8EA02B, 32'h3DCCCCCD, 32'hBF19999A,
		32'h3EB33333, 32'hBE4CCCCD, 32'h3F4CCCCD,
		32'hBDCCCCCD, 32'h3E19999A, 32'hBF000000,
		32'h3F266666, 32'hBEB33333, 32'h3D4CCCCD,
		32'hBF4CCCCD, 32'h3E800000, 32'hBE800000,
		32'h3F59999A, 32'hBD4CCCCD, 32'h3EE66666,
		32'hBF266666, 32'h3E0F5C29, 32'hBE0F5C29,
		32'h3F733333, 32'hBEE66666, 32'h3D23D70A,
		32'hBF59999A, 32'h3ECCCCCD, 32'hBECCCCCD
	};

endpackage
